//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_rv_decode
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/rv_decode_pkg.sv
package rv_decode_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Major opcodes, instr[6:0]
  localparam logic [6:0] OPCODE_LUI      = 7'b0110111;
  localparam logic [6:0] OPCODE_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPCODE_JAL      = 7'b1101111;
  localparam logic [6:0] OPCODE_JALR     = 7'b1100111;
  localparam logic [6:0] OPCODE_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPCODE_LOAD     = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE    = 7'b0100011;
  localparam logic [6:0] OPCODE_OPIMM    = 7'b0010011;
  localparam logic [6:0] OPCODE_OP       = 7'b0110011;
  localparam logic [6:0] OPCODE_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OPCODE_SYSTEM   = 7'b1110011;

  typedef enum logic [4:0] {
    ALU_ADD  = 5'h00,
    ALU_SUB  = 5'h01,
    ALU_AND  = 5'h02,
    ALU_OR   = 5'h03,
    ALU_XOR  = 5'h04,
    ALU_SLL  = 5'h05,
    ALU_SRL  = 5'h06,
    ALU_SRA  = 5'h07,
    ALU_SLT  = 5'h08,
    ALU_SLTU = 5'h09,
    ALU_EQ   = 5'h0a,  // Branch compares from here on
    ALU_NE   = 5'h0b,
    ALU_LT   = 5'h0c,
    ALU_GE   = 5'h0d,
    ALU_LTU  = 5'h0e,
    ALU_GEU  = 5'h0f
  } alu_opcode_e;

  // Values follow funct3[1:0] of the M encodings
  typedef enum logic [1:0] {MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU} mul_opcode_e;
  typedef enum logic [1:0] {DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU} div_opcode_e;

  typedef enum logic [1:0] {CSR_OP_READ, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR} csr_opcode_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_REG, OP_B_IMM} op_b_sel_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

  ////////////////////////////////////////////////////////////////////////////
  // Control word and pipeline payloads
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        illegal_insn;
    logic        alu_en;
    logic        alu_bch;       // ALU does the branch compare
    logic        alu_jmp;       // ALU forms the link address
    alu_opcode_e alu_operator;
    op_a_sel_e   alu_op_a_sel;
    op_b_sel_e   alu_op_b_sel;
    imm_sel_e    imm_sel;
    logic        mul_en;
    mul_opcode_e mul_operator;
    logic        div_en;
    div_opcode_e div_operator;
    logic        csr_en;
    csr_opcode_e csr_op;
    logic        lsu_en;
    logic        lsu_we;
    logic [1:0]  lsu_type;      // Byte, half or word
    logic        lsu_sign_ext;
    logic        rf_we;
    logic [1:0]  rf_re;         // Bit 0 rs1, bit 1 rs2
    logic        sys_en;
    logic        sys_ecall;
    logic        sys_ebrk;
    logic        sys_mret;
    logic        sys_wfi;
    logic        sys_fencei;
  } decoder_ctrl_t;

  // No sub-decoder match, nothing enabled
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL_INSN = '{
    illegal_insn : 1'b1,
    alu_en       : 1'b0,
    alu_bch      : 1'b0,
    alu_jmp      : 1'b0,
    alu_operator : ALU_ADD,
    alu_op_a_sel : OP_A_REG,
    alu_op_b_sel : OP_B_REG,
    imm_sel      : IMM_I,
    mul_en       : 1'b0,
    mul_operator : MUL_MUL,
    div_en       : 1'b0,
    div_operator : DIV_DIV,
    csr_en       : 1'b0,
    csr_op       : CSR_OP_READ,
    lsu_en       : 1'b0,
    lsu_we       : 1'b0,
    lsu_type     : 2'b00,
    lsu_sign_ext : 1'b0,
    rf_we        : 1'b0,
    rf_re        : 2'b00,
    sys_en       : 1'b0,
    sys_ecall    : 1'b0,
    sys_ebrk     : 1'b0,
    sys_mret     : 1'b0,
    sys_wfi      : 1'b0,
    sys_fencei   : 1'b0
  };

  typedef struct packed {
    logic        valid;
    logic [31:0] instr;
    logic        illegal_c_insn;  // Compressed expander found no match
    logic        bus_err;         // Fetch bus error, word is not real
  } fetch_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] instr;
    logic        illegal_c_insn;
    logic        bus_err;
  } if_id_pipe_t;

  typedef struct packed {
    logic          valid;
    decoder_ctrl_t ctrl;
    logic [31:0]   instr;         // Kept for the trap value
  } id_ex_pipe_t;

endpackage

//--- rtl/rv_decode_top.sv
`timescale 1ns/1ps

module rv_decode_top (
  input  logic                       clk,
  input  logic                       reset_i,
  input  rv_decode_pkg::fetch_t      fetch_i,
  input  logic                       stall_i,
  input  logic                       flush_i,
  output rv_decode_pkg::id_ex_pipe_t id_ex_o
);

  rv_decode_pkg::if_id_pipe_t   if_id;  // Fetched word in decode
  rv_decode_pkg::decoder_ctrl_t ctrl;   // Gated control for execute

  rv_if_id_pipe u_if_id_pipe (
    .clk     ( clk     ),
    .reset_i ( reset_i ),
    .fetch_i ( fetch_i ),
    .stall_i ( stall_i ),
    .flush_i ( flush_i ),
    .if_id_o ( if_id   )
  );

  rv_decoder u_decoder (
    .if_id_i ( if_id ),
    .ctrl_o  ( ctrl  )
  );

  rv_id_ex_pipe u_id_ex_pipe (
    .clk     ( clk     ),
    .reset_i ( reset_i ),
    .if_id_i ( if_id   ),
    .ctrl_i  ( ctrl    ),
    .stall_i ( stall_i ),
    .flush_i ( flush_i ),
    .id_ex_o ( id_ex_o )
  );

endmodule

//--- rtl/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
  input  rv_decode_pkg::if_id_pipe_t   if_id_i,
  output rv_decode_pkg::decoder_ctrl_t ctrl_o
);

  rv_decode_pkg::decoder_ctrl_t i_ctrl;
  rv_decode_pkg::decoder_ctrl_t m_ctrl;
  rv_decode_pkg::decoder_ctrl_t subdec_ctrl;  // Winner of the sub-decoders
  rv_decode_pkg::decoder_ctrl_t merged_ctrl;  // After the compressed check

  rv_i_decoder u_i_decoder (
    .instr_i ( if_id_i.instr ),
    .ctrl_o  ( i_ctrl        )
  );

  rv_m_decoder u_m_decoder (
    .instr_i ( if_id_i.instr ),
    .ctrl_o  ( m_ctrl        )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Priority merge, M first then base ISA
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (!m_ctrl.illegal_insn) begin
      subdec_ctrl = m_ctrl;
    end else if (!i_ctrl.illegal_insn) begin
      subdec_ctrl = i_ctrl;
    end else begin
      subdec_ctrl = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;  // Nobody matched
    end
  end

  // Expander already rejected the halfword, ignore what it turned into
  assign merged_ctrl = if_id_i.illegal_c_insn ? rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN :
                                                subdec_ctrl;

  // Fetch error, the word is garbage so nothing may take effect
  always_comb begin
    ctrl_o = merged_ctrl;
    if (if_id_i.bus_err) begin
      ctrl_o.illegal_insn = 1'b0;  // Bus error trap wins over illegal
      ctrl_o.alu_en       = 1'b0;
      ctrl_o.mul_en       = 1'b0;
      ctrl_o.div_en       = 1'b0;
      ctrl_o.lsu_en       = 1'b0;
      ctrl_o.csr_en       = 1'b0;
      ctrl_o.csr_op       = rv_decode_pkg::CSR_OP_READ;
      ctrl_o.rf_we        = 1'b0;
      ctrl_o.sys_en       = 1'b0;
      ctrl_o.sys_ecall    = 1'b0;
      ctrl_o.sys_ebrk     = 1'b0;
      ctrl_o.sys_mret     = 1'b0;
      ctrl_o.sys_wfi      = 1'b0;
      ctrl_o.sys_fencei   = 1'b0;
    end
  end

endmodule

//--- rtl/rv_i_decoder.sv
`timescale 1ns/1ps

module rv_i_decoder (
  input  logic [31:0]                  instr_i,
  output rv_decode_pkg::decoder_ctrl_t ctrl_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic       illegal;  // Set by any failed field check
  rv_decode_pkg::decoder_ctrl_t ctrl;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];

  always_comb begin
    ctrl              = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
    ctrl.illegal_insn = 1'b0;  // Start from an all-off legal word
    illegal           = 1'b0;

    case (opcode)
      rv_decode_pkg::OPCODE_LUI, rv_decode_pkg::OPCODE_AUIPC: begin
        ctrl.alu_en       = 1'b1;
        ctrl.alu_op_a_sel = opcode[5] ? rv_decode_pkg::OP_A_ZERO : rv_decode_pkg::OP_A_PC;
        ctrl.alu_op_b_sel = rv_decode_pkg::OP_B_IMM;
        ctrl.imm_sel      = rv_decode_pkg::IMM_U;
        ctrl.rf_we        = 1'b1;
      end

      rv_decode_pkg::OPCODE_JAL, rv_decode_pkg::OPCODE_JALR: begin
        ctrl.alu_en       = 1'b1;
        ctrl.alu_jmp      = 1'b1;                       // ALU makes PC + 4
        ctrl.alu_op_a_sel = rv_decode_pkg::OP_A_PC;
        ctrl.alu_op_b_sel = rv_decode_pkg::OP_B_IMM;
        ctrl.imm_sel      = opcode[3] ? rv_decode_pkg::IMM_J : rv_decode_pkg::IMM_I;
        ctrl.rf_we        = 1'b1;
        ctrl.rf_re        = {1'b0, ~opcode[3]};         // JALR reads rs1
        illegal           = !opcode[3] && (funct3 != 3'b000);
      end

      rv_decode_pkg::OPCODE_BRANCH: begin
        ctrl.alu_en  = 1'b1;
        ctrl.alu_bch = 1'b1;
        ctrl.imm_sel = rv_decode_pkg::IMM_B;
        ctrl.rf_re   = 2'b11;
        case (funct3)
          3'b000:  ctrl.alu_operator = rv_decode_pkg::ALU_EQ;
          3'b001:  ctrl.alu_operator = rv_decode_pkg::ALU_NE;
          3'b100:  ctrl.alu_operator = rv_decode_pkg::ALU_LT;
          3'b101:  ctrl.alu_operator = rv_decode_pkg::ALU_GE;
          3'b110:  ctrl.alu_operator = rv_decode_pkg::ALU_LTU;
          3'b111:  ctrl.alu_operator = rv_decode_pkg::ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end

      rv_decode_pkg::OPCODE_LOAD: begin
        ctrl.lsu_en       = 1'b1;
        ctrl.lsu_type     = funct3[1:0];
        ctrl.lsu_sign_ext = ~funct3[2];                 // LBU and LHU zero extend
        ctrl.alu_op_b_sel = rv_decode_pkg::OP_B_IMM;
        ctrl.rf_we        = 1'b1;
        ctrl.rf_re        = 2'b01;
        illegal           = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end

      rv_decode_pkg::OPCODE_STORE: begin
        ctrl.lsu_en       = 1'b1;
        ctrl.lsu_we       = 1'b1;
        ctrl.lsu_type     = funct3[1:0];
        ctrl.alu_op_b_sel = rv_decode_pkg::OP_B_IMM;
        ctrl.imm_sel      = rv_decode_pkg::IMM_S;
        ctrl.rf_re        = 2'b11;
        illegal           = funct3[2] || (funct3[1:0] == 2'b11);
      end

      rv_decode_pkg::OPCODE_OPIMM: begin
        ctrl.alu_en       = 1'b1;
        ctrl.alu_op_b_sel = rv_decode_pkg::OP_B_IMM;
        ctrl.rf_we        = 1'b1;
        ctrl.rf_re        = 2'b01;
        case (funct3)
          3'b000: ctrl.alu_operator = rv_decode_pkg::ALU_ADD;
          3'b010: ctrl.alu_operator = rv_decode_pkg::ALU_SLT;
          3'b011: ctrl.alu_operator = rv_decode_pkg::ALU_SLTU;
          3'b100: ctrl.alu_operator = rv_decode_pkg::ALU_XOR;
          3'b110: ctrl.alu_operator = rv_decode_pkg::ALU_OR;
          3'b111: ctrl.alu_operator = rv_decode_pkg::ALU_AND;
          3'b001: begin
            ctrl.alu_operator = rv_decode_pkg::ALU_SLL;
            illegal           = (funct7 != 7'b0000000);  // shamt[5] is reserved
          end
          default: begin                                 // SRLI or SRAI
            ctrl.alu_operator = funct7[5] ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
            illegal           = ({funct7[6], funct7[4:0]} != 6'b0);
          end
        endcase
      end

      rv_decode_pkg::OPCODE_OP: begin
        ctrl.alu_en = 1'b1;
        ctrl.rf_we  = 1'b1;
        ctrl.rf_re  = 2'b11;
        illegal     = ({funct7[6], funct7[4:0]} != 6'b0);  // M words land here too
        case ({funct7[5], funct3})
          4'b0_000: ctrl.alu_operator = rv_decode_pkg::ALU_ADD;
          4'b1_000: ctrl.alu_operator = rv_decode_pkg::ALU_SUB;
          4'b0_001: ctrl.alu_operator = rv_decode_pkg::ALU_SLL;
          4'b0_010: ctrl.alu_operator = rv_decode_pkg::ALU_SLT;
          4'b0_011: ctrl.alu_operator = rv_decode_pkg::ALU_SLTU;
          4'b0_100: ctrl.alu_operator = rv_decode_pkg::ALU_XOR;
          4'b0_101: ctrl.alu_operator = rv_decode_pkg::ALU_SRL;
          4'b1_101: ctrl.alu_operator = rv_decode_pkg::ALU_SRA;
          4'b0_110: ctrl.alu_operator = rv_decode_pkg::ALU_OR;
          4'b0_111: ctrl.alu_operator = rv_decode_pkg::ALU_AND;
          default:  illegal = 1'b1;
        endcase
      end

      rv_decode_pkg::OPCODE_MISC_MEM: begin
        // FENCE is a no-op on this core, FENCE.I traps to the controller
        ctrl.sys_en     = funct3[0];
        ctrl.sys_fencei = funct3[0];
        illegal         = (funct3[2:1] != 2'b00) || (rd != 5'd0) || (rs1 != 5'd0) ||
                          (funct3[0] && (instr_i[31:20] != 12'h000));
      end

      rv_decode_pkg::OPCODE_SYSTEM: begin
        if (funct3 == 3'b000) begin
          ctrl.sys_en = 1'b1;
          illegal     = (rd != 5'd0) || (rs1 != 5'd0);
          case (instr_i[31:20])
            12'h000: ctrl.sys_ecall = 1'b1;
            12'h001: ctrl.sys_ebrk  = 1'b1;
            12'h302: ctrl.sys_mret  = 1'b1;
            12'h105: ctrl.sys_wfi   = 1'b1;
            default: illegal = 1'b1;
          endcase
        end else begin
          ctrl.csr_en = 1'b1;
          ctrl.rf_we  = 1'b1;
          ctrl.rf_re  = {1'b0, ~funct3[2]};            // Immediate forms carry uimm in rs1
          case (funct3[1:0])
            2'b01:   ctrl.csr_op = rv_decode_pkg::CSR_OP_WRITE;
            2'b10:   ctrl.csr_op = (rs1 == 5'd0) ? rv_decode_pkg::CSR_OP_READ :
                                                   rv_decode_pkg::CSR_OP_SET;
            2'b11:   ctrl.csr_op = (rs1 == 5'd0) ? rv_decode_pkg::CSR_OP_READ :
                                                   rv_decode_pkg::CSR_OP_CLEAR;
            default: illegal = 1'b1;                    // funct3 100 is reserved
          endcase
        end
      end

      default: illegal = 1'b1;
    endcase
  end

  assign ctrl_o = illegal ? rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN : ctrl;

endmodule

//--- rtl/rv_id_ex_pipe.sv
`timescale 1ns/1ps

module rv_id_ex_pipe (
  input  logic                         clk,
  input  logic                         reset_i,
  input  rv_decode_pkg::if_id_pipe_t   if_id_i,
  input  rv_decode_pkg::decoder_ctrl_t ctrl_i,
  input  logic                         stall_i,
  input  logic                         flush_i,
  output rv_decode_pkg::id_ex_pipe_t   id_ex_o
);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      id_ex_o.valid             <= 1'b0;
      id_ex_o.ctrl              <= rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
      id_ex_o.ctrl.illegal_insn <= 1'b0;  // All-off word, no trap pending
    end else if (flush_i) begin
      id_ex_o.valid <= 1'b0;              // Flush beats stall
    end else if (!stall_i) begin
      id_ex_o.valid <= if_id_i.valid;     // Valid travels with its word
      id_ex_o.ctrl  <= ctrl_i;
      id_ex_o.instr <= if_id_i.instr;     // mtval source on illegal
    end
  end

endmodule

//--- rtl/rv_if_id_pipe.sv
`timescale 1ns/1ps

module rv_if_id_pipe (
  input  logic                       clk,
  input  logic                       reset_i,
  input  rv_decode_pkg::fetch_t      fetch_i,
  input  logic                       stall_i,
  input  logic                       flush_i,
  output rv_decode_pkg::if_id_pipe_t if_id_o
);

  always_ff @(posedge clk) begin
    // Valid bit, flush beats stall
    if (reset_i || flush_i) begin
      if_id_o.valid <= 1'b0;
    end else if (!stall_i) begin
      if_id_o.valid <= fetch_i.valid;
    end

    // Payload only moves with a real word
    if (!stall_i && fetch_i.valid) begin
      if_id_o.instr          <= fetch_i.instr;
      if_id_o.illegal_c_insn <= fetch_i.illegal_c_insn;
      if_id_o.bus_err        <= fetch_i.bus_err;
    end
  end

endmodule

//--- rtl/rv_m_decoder.sv
`timescale 1ns/1ps

module rv_m_decoder (
  input  logic [31:0]                  instr_i,
  output rv_decode_pkg::decoder_ctrl_t ctrl_o
);

  logic       m_match;  // OP with funct7 0000001
  logic [2:0] funct3;

  assign funct3  = instr_i[14:12];
  assign m_match = (instr_i[6:0] == rv_decode_pkg::OPCODE_OP) &&
                   (instr_i[31:25] == 7'b0000001);

  always_comb begin
    ctrl_o = rv_decode_pkg::DECODER_CTRL_ILLEGAL_INSN;
    if (m_match) begin
      ctrl_o.illegal_insn = 1'b0;
      ctrl_o.rf_we        = 1'b1;
      ctrl_o.rf_re        = 2'b11;  // Both sources always read
      if (!funct3[2]) begin
        ctrl_o.mul_en       = 1'b1;  // MUL, MULH, MULHSU, MULHU
        ctrl_o.mul_operator = rv_decode_pkg::mul_opcode_e'(funct3[1:0]);
      end else begin
        ctrl_o.div_en       = 1'b1;  // DIV, DIVU, REM, REMU
        ctrl_o.div_operator = rv_decode_pkg::div_opcode_e'(funct3[1:0]);
      end
    end
  end

endmodule

//--- src.f
rtl/rv_decode_pkg.sv
rtl/rv_if_id_pipe.sv
rtl/rv_i_decoder.sv
rtl/rv_m_decoder.sv
rtl/rv_decoder.sv
rtl/rv_id_ex_pipe.sv
rtl/rv_decode_top.sv
verification/tb_rv_decode.sv

//--- verification/decode_input.txt
// instr illegal_c bus_err | illegal alu_en mul_en div_en lsu_en lsu_we lsu_type rf_we csr_en
// | sys_ecall sys_ebrk sys_mret sys_wfi sys_fencei | alu_operator, all hex
00500093 0 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 00
402081b3 0 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 01
40335293 0 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 07
0020b233 0 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 09
00209463 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0b
0020f463 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0f
010000ef 0 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 00
000280e7 0 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 00
00412303 0 0 0 0 0 0 1 0 2 1 0 0 0 0 0 0 00
0000c383 0 0 0 0 0 0 1 0 0 1 0 0 0 0 0 0 00
00209323 0 0 0 0 0 0 1 1 1 0 0 0 0 0 0 0 00
12345437 0 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 00
300110f3 0 0 0 0 0 0 0 0 0 1 1 0 0 0 0 0 00
b00021f3 0 0 0 0 0 0 0 0 0 1 1 0 0 0 0 0 00
022081b3 0 0 0 0 1 0 0 0 0 1 0 0 0 0 0 0 00
0220b1b3 0 0 0 0 1 0 0 0 0 1 0 0 0 0 0 0 00
0220d1b3 0 0 0 0 0 1 0 0 0 1 0 0 0 0 0 0 00
0220e1b3 0 0 0 0 0 1 0 0 0 1 0 0 0 0 0 0 00
00000073 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 00
00100073 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 00
30200073 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 00
10500073 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 00
0000100f 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 00
0ff0000f 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00
402091b3 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 00
00000000 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 00
0020a463 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 00
00500093 1 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 00
00412303 0 1 0 0 0 0 0 0 2 0 0 0 0 0 0 0 00
300130f3 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00
00000073 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00
022081b3 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00

//--- verification/tb_rv_decode.sv
`timescale 1ns/1ps

module tb_rv_decode;

  localparam int unsigned SEED       = 32'h5b8e5343;
  localparam int          IDLE_LIMIT = 64;  // Cycles without an output word
  localparam int          FLUSH_AT   = 12;  // Vector index that triggers the flush

  // One line of the vector file
  typedef struct packed {
    logic [31:0] instr;
    logic        illegal_c;
    logic        bus_err;
    logic        illegal;
    logic        alu_en;
    logic        mul_en;
    logic        div_en;
    logic        lsu_en;
    logic        lsu_we;
    logic [1:0]  lsu_type;
    logic        rf_we;
    logic        csr_en;
    logic [4:0]  sys;       // ecall, ebrk, mret, wfi, fencei
    logic [4:0]  alu_op;
  } vector_t;

  logic                       clk;
  logic                       reset_i;
  rv_decode_pkg::fetch_t      fetch_i;
  logic                       stall_i;
  logic                       flush_i;
  rv_decode_pkg::id_ex_pipe_t id_ex_o;

  vector_t vecs[$];
  int      pend_q[$];  // Accepted words still in the pipeline
  int      mismatches;
  int      other_errors;
  int      checked;
  int      dropped;
  bit      timed_out;

  rv_decode_top u_dut (
    .clk     ( clk     ),
    .reset_i ( reset_i ),
    .fetch_i ( fetch_i ),
    .stall_i ( stall_i ),
    .flush_i ( flush_i ),
    .id_ex_o ( id_ex_o )
  );

  always #10 clk = ~clk;  // 20 ns period

  ////////////////////////////////////////////////////////////////////////////
  // Vector file and field checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    int unsigned f [18];
    vector_t     v;
    fd = $fopen("verification/decode_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open vector file verification/decode_input.txt");
      other_errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 8 && line.substr(0, 1) != "//") begin  // Skip header and blanks
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                    f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
        if (n != 18) begin
          $display("bad vector line: %s", line);
          other_errors++;
        end else begin
          v.instr     = f[0];
          v.illegal_c = f[1][0];
          v.bus_err   = f[2][0];
          v.illegal   = f[3][0];
          v.alu_en    = f[4][0];
          v.mul_en    = f[5][0];
          v.div_en    = f[6][0];
          v.lsu_en    = f[7][0];
          v.lsu_we    = f[8][0];
          v.lsu_type  = f[9][1:0];
          v.rf_we     = f[10][0];
          v.csr_en    = f[11][0];
          v.sys       = {f[12][0], f[13][0], f[14][0], f[15][0], f[16][0]};
          v.alu_op    = f[17][4:0];
          vecs.push_back(v);
        end
      end
    end
    $fclose(fd);
  endtask

  // M extension table, funct3 picks the multiply or divide variant
  function automatic logic [1:0] expected_m_operator(input logic [2:0] funct3);
    case (funct3)
      3'b000:  return rv_decode_pkg::MUL_MUL;
      3'b001:  return rv_decode_pkg::MUL_MULH;
      3'b010:  return rv_decode_pkg::MUL_MULHSU;
      3'b011:  return rv_decode_pkg::MUL_MULHU;
      3'b100:  return rv_decode_pkg::DIV_DIV;
      3'b101:  return rv_decode_pkg::DIV_DIVU;
      3'b110:  return rv_decode_pkg::DIV_REM;
      default: return rv_decode_pkg::DIV_REMU;
    endcase
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp,
                             input logic [31:0] act, input int idx);
    if (exp !== act) begin
      mismatches++;
      $display("mismatch %s vector %0d exp=%h act=%h", name, idx, exp, act);
    end
  endtask

  // Reset state, nothing valid and nothing enabled
  task automatic check_idle();
    rv_decode_pkg::decoder_ctrl_t c;
    c = id_ex_o.ctrl;
    check_field("id_ex_o.valid", 32'd0, 32'(id_ex_o.valid), -1);
    check_field("illegal_insn", 32'd0, 32'(c.illegal_insn), -1);
    check_field("alu_en", 32'd0, 32'(c.alu_en), -1);
    check_field("mul_en", 32'd0, 32'(c.mul_en), -1);
    check_field("div_en", 32'd0, 32'(c.div_en), -1);
    check_field("lsu_en", 32'd0, 32'(c.lsu_en), -1);
    check_field("csr_en", 32'd0, 32'(c.csr_en), -1);
    check_field("rf_we", 32'd0, 32'(c.rf_we), -1);
    check_field("sys_en", 32'd0, 32'(c.sys_en), -1);
  endtask

  task automatic compare_word(input vector_t v, input int idx);
    rv_decode_pkg::decoder_ctrl_t c;
    logic [4:0]                   sys;
    logic [1:0]                   m_op;
    c    = id_ex_o.ctrl;
    sys  = {c.sys_ecall, c.sys_ebrk, c.sys_mret, c.sys_wfi, c.sys_fencei};
    m_op = expected_m_operator(v.instr[14:12]);
    check_field("instr", v.instr, id_ex_o.instr, idx);
    check_field("illegal_insn", 32'(v.illegal), 32'(c.illegal_insn), idx);
    check_field("alu_en", 32'(v.alu_en), 32'(c.alu_en), idx);
    check_field("mul_en", 32'(v.mul_en), 32'(c.mul_en), idx);
    check_field("div_en", 32'(v.div_en), 32'(c.div_en), idx);
    check_field("lsu_en", 32'(v.lsu_en), 32'(c.lsu_en), idx);
    check_field("lsu_we", 32'(v.lsu_we), 32'(c.lsu_we), idx);
    check_field("lsu_type", 32'(v.lsu_type), 32'(c.lsu_type), idx);
    check_field("rf_we", 32'(v.rf_we), 32'(c.rf_we), idx);
    check_field("csr_en", 32'(v.csr_en), 32'(c.csr_en), idx);
    check_field("sys_bits", 32'(v.sys), 32'(sys), idx);
    check_field("sys_en", 32'(|v.sys), 32'(c.sys_en), idx);  // Any trap class needs it
    check_field("alu_operator", 32'(v.alu_op), 32'(c.alu_operator), idx);
    if (v.mul_en) begin
      check_field("mul_operator", 32'(m_op), 32'(c.mul_operator), idx);
    end
    if (v.div_en) begin
      check_field("div_operator", 32'(m_op), 32'(c.div_operator), idx);
    end
    if (v.bus_err) begin  // Suppressed CSR access falls back to a read
      check_field("csr_op", 32'(rv_decode_pkg::CSR_OP_READ), 32'(c.csr_op), idx);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stream with random stalls and one flush
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_stream();
    int ptr;
    int idle;
    int idx;
    bit stall;
    bit flush;
    bit flushed;
    ptr     = 0;
    idle    = 0;
    flushed = 1'b0;
    while ((ptr < vecs.size() || pend_q.size() > 0) && !timed_out) begin
      stall = ($urandom % 4) == 0;  // About one cycle in four
      flush = 1'b0;
      if (!flushed && ptr >= FLUSH_AT && pend_q.size() > 1) begin
        flush   = 1'b1;  // Both registers hold a word here
        stall   = 1'b0;
        flushed = 1'b1;
      end
      stall_i = stall;
      flush_i = flush;

      // Execute takes the ID/EX word at the next unstalled edge
      if (id_ex_o.valid && !stall) begin
        if (pend_q.size() == 0) begin
          $display("id_ex delivered a word that was never fetched");
          other_errors++;
        end else begin
          idx = pend_q.pop_front();
          compare_word(vecs[idx], idx);
          checked++;
        end
        idle = 0;
      end else begin
        idle++;
      end

      // Flush kills the younger words, fetch restarts at the oldest one
      if (flush && pend_q.size() > 0) begin
        ptr     = pend_q[0];
        dropped = dropped + pend_q.size();
        pend_q.delete();
      end

      if (ptr < vecs.size()) begin
        fetch_i.valid          = 1'b1;  // Held until accepted
        fetch_i.instr          = vecs[ptr].instr;
        fetch_i.illegal_c_insn = vecs[ptr].illegal_c;
        fetch_i.bus_err        = vecs[ptr].bus_err;
        if (!stall && !flush) begin
          pend_q.push_back(ptr);
          ptr++;
        end
      end else begin
        fetch_i.valid = 1'b0;
      end

      if (idle > IDLE_LIMIT) begin
        $display("timeout waiting for id_ex valid");
        other_errors++;
        timed_out = 1'b1;
      end
      @(negedge clk);
    end
    if (!flushed && !timed_out) begin
      $display("flush was never issued during the stream");
      other_errors++;
    end
    fetch_i.valid = 1'b0;
    stall_i       = 1'b0;
    flush_i       = 1'b0;
  endtask

  initial begin
    clk          = 1'b0;
    reset_i      = 1'b1;
    fetch_i      = '0;
    stall_i      = 1'b0;
    flush_i      = 1'b0;
    mismatches   = 0;
    other_errors = 0;
    checked      = 0;
    dropped      = 0;
    timed_out    = 1'b0;
    void'($urandom(SEED));
    load_vectors();
    if (vecs.size() == 0) begin
      $display("no vectors loaded");
      other_errors++;
    end

    repeat (16) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    check_idle();  // Before any fetch word

    if (vecs.size() > 0) begin
      run_stream();
    end
    if (!timed_out && checked != vecs.size()) begin
      $display("only %0d of %0d vectors reached id_ex", checked, vecs.size());
      other_errors++;
    end

    $display("errors: %0d mismatches, %0d other; %0d of %0d words checked, %0d flushed",
             mismatches, other_errors, checked, vecs.size(), dropped);
    if (mismatches == 0 && other_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
